//--- verilog/rp_defines.svh
/*
 * widths and bus layout shared by all RTL files, single adc_clk domain
 * region field is 3 bits wide, so RP_REGIONS must stay at 8
 */
`ifndef RP_DEFINES_SVH
`define RP_DEFINES_SVH

// system bus
`define RP_BUS_W       32            // address and data width
`define RP_REGIONS     8             // regions on the system bus
`define RP_REGION_LSB  20            // region field is addr[22:20]

// fast analog edge
`define RP_ADC_W       14            // converter sample width
`define RP_ADC_PIN_W   16            // ADC pin bus, bits 1:0 unused

// slow digital i/o
`define RP_EXP_W       8             // expansion pins per row
`define RP_LED_W       8             // LED count

// housekeeping id word, read only
`define RP_HK_ID       32'h5250_0001

`endif

//--- verilog/rp_pkg.sv
/*
 * shared types: bus regions, register offsets, sample format
 * offsets are byte addresses inside a region, word aligned
 */
`include "rp_defines.svh"

package rp_pkg;

  // bus region, addr[22:20]; codes 2..7 have no slave
  typedef enum logic [2:0] {
    REGION_HK     = 3'd0,
    REGION_ANALOG = 3'd1
  } region_e;

  // housekeeping block offsets
  typedef enum logic [7:0] {
    HK_ID        = 8'h00,   // read only
    HK_LOOP      = 8'h04,   // bit 0 = digital loopback
    HK_EXP_P_DIR = 8'h10,   // 1 = pin drives
    HK_EXP_N_DIR = 8'h14,
    HK_EXP_P_OUT = 8'h18,
    HK_EXP_N_OUT = 8'h1C,
    HK_EXP_P_IN  = 8'h20,   // read only
    HK_EXP_N_IN  = 8'h24,   // read only
    HK_LED       = 8'h30
  } hk_reg_e;

  // analog block offsets
  typedef enum logic [7:0] {
    AN_DAC_A = 8'h00,
    AN_DAC_B = 8'h04,
    AN_ADC_A = 8'h08,       // read only
    AN_ADC_B = 8'h0C        // read only
  } analog_reg_e;

  // two's complement converter sample
  typedef logic signed [`RP_ADC_W-1:0] sample_t;

endpackage

//--- verilog/sys_bus_if.sv
/*
 * one system bus region between the decoder and a register block
 * strobes are single-cycle, no byte select, no back-pressure
 */
`include "rp_defines.svh"

interface sys_bus_if;

  logic [`RP_BUS_W-1:0] addr;   // word aligned, bits 1:0 zero
  logic [`RP_BUS_W-1:0] wdata;
  logic                 wen;    // write strobe, one cycle
  logic                 ren;    // read strobe, one cycle
  logic [`RP_BUS_W-1:0] rdata;  // valid with ack
  logic                 err;    // unmapped offset
  logic                 ack;    // one cycle after strobe

  modport decoder (
    output addr, wdata, wen, ren,
    input  rdata, err, ack
  );

  modport slave (
    input  addr, wdata, wen, ren,
    output rdata, err, ack
  );

endinterface

//--- verilog/sys_bus_decoder.sv
/*
 * splits the bus into 8 regions on addr[22:20]; regions 2..7 answer
 * with zero data and no error one cycle after the strobe
 * slave responses land on the host 2 cycles after the strobe
 * host must hold off the next strobe until sys_ack_o
 */
`include "rp_defines.svh"

module sys_bus_decoder (
  input  logic                 adc_clk,
  input  logic                 rst_i,
  input  logic [`RP_BUS_W-1:0] sys_addr_i,
  input  logic [`RP_BUS_W-1:0] sys_wdata_i,
  input  logic                 sys_wen_i,
  input  logic                 sys_ren_i,
  output logic [`RP_BUS_W-1:0] sys_rdata_o,
  output logic                 sys_err_o,
  output logic                 sys_ack_o,
  sys_bus_if.decoder           hk_bus,
  sys_bus_if.decoder           analog_bus
);

  ////////////////////////////////////////////////////
  // region decode
  ////////////////////////////////////////////////////

  logic [`RP_BUS_W-1:0]  addr;
  rp_pkg::region_e       region;
  logic [`RP_REGIONS-1:0] sel;                  // one-hot region select
  logic                  strobe;

  assign addr   = {sys_addr_i[`RP_BUS_W-1:2], 2'b00};  // 32-bit words only
  assign region = rp_pkg::region_e'(addr[`RP_REGION_LSB +: $bits(rp_pkg::region_e)]);
  assign sel    = {{(`RP_REGIONS-1){1'b0}}, 1'b1} << region;
  assign strobe = sys_wen_i | sys_ren_i;

  // same address and data to both slaves, strobes gated per region
  assign hk_bus.addr      = addr;
  assign hk_bus.wdata     = sys_wdata_i;
  assign hk_bus.wen       = sys_wen_i & sel[rp_pkg::REGION_HK];
  assign hk_bus.ren       = sys_ren_i & sel[rp_pkg::REGION_HK];
  assign analog_bus.addr  = addr;
  assign analog_bus.wdata = sys_wdata_i;
  assign analog_bus.wen   = sys_wen_i & sel[rp_pkg::REGION_ANALOG];
  assign analog_bus.ren   = sys_ren_i & sel[rp_pkg::REGION_ANALOG];

  ////////////////////////////////////////////////////
  // per-region responses
  ////////////////////////////////////////////////////

  logic [`RP_BUS_W-1:0]   resp_rdata [`RP_REGIONS];
  logic [`RP_REGIONS-1:0] resp_ack;
  logic [`RP_REGIONS-1:0] resp_err;

  always_comb
  begin
    // empty regions: immediate ack, zero data
    for (int i = 0; i < `RP_REGIONS; i++)
    begin
      resp_rdata[i] = '0;
      resp_ack[i]   = strobe & sel[i];
      resp_err[i]   = 1'b0;
    end
    resp_rdata[rp_pkg::REGION_HK]     = hk_bus.rdata;
    resp_ack[rp_pkg::REGION_HK]       = hk_bus.ack;
    resp_err[rp_pkg::REGION_HK]       = hk_bus.err;
    resp_rdata[rp_pkg::REGION_ANALOG] = analog_bus.rdata;
    resp_ack[rp_pkg::REGION_ANALOG]   = analog_bus.ack;
    resp_err[rp_pkg::REGION_ANALOG]   = analog_bus.err;
  end

  ////////////////////////////////////////////////////
  // response registers
  ////////////////////////////////////////////////////

  logic [`RP_BUS_W-1:0]   rdata_q [`RP_REGIONS];
  logic [`RP_REGIONS-1:0] ack_q;
  logic [`RP_REGIONS-1:0] err_q;
  rp_pkg::region_e        region_q;             // region of the open request

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      ack_q    <= '0;
      err_q    <= '0;
      region_q <= rp_pkg::REGION_HK;
    end
    else
    begin
      ack_q <= resp_ack;
      err_q <= resp_err;
      if (strobe)
        region_q <= region;                     // held until the next strobe
    end
  end

  always_ff @(posedge adc_clk)
  begin
    rdata_q <= resp_rdata;
  end

  // pick the answer of the requested region
  assign sys_rdata_o = rdata_q[region_q];
  assign sys_ack_o   = ack_q[region_q];
  assign sys_err_o   = err_q[region_q];

endmodule

//--- verilog/housekeeping_regs.sv
/*
 * region 0: LEDs, digital loopback, expansion connector control
 * offset decode uses addr[7:0] only, higher bits alias
 * expansion inputs are sampled as is, no synchronizer in front
 */
`include "rp_defines.svh"

module housekeeping_regs (
  input  logic                adc_clk,
  input  logic                rst_i,
  sys_bus_if.slave            bus,
  input  logic [`RP_EXP_W-1:0] exp_p_dat_i,
  input  logic [`RP_EXP_W-1:0] exp_n_dat_i,
  output logic [`RP_LED_W-1:0] led_o,
  output logic [`RP_EXP_W-1:0] exp_p_dat_o,
  output logic [`RP_EXP_W-1:0] exp_n_dat_o,
  output logic [`RP_EXP_W-1:0] exp_p_dir_o,
  output logic [`RP_EXP_W-1:0] exp_n_dir_o,
  output logic                digital_loop_o
);

  rp_pkg::hk_reg_e      offset;
  logic                 hit;                    // offset is mapped
  logic [`RP_BUS_W-1:0] rd_val;

  assign offset = rp_pkg::hk_reg_e'(bus.addr[7:0]);

  ////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////

  always_comb
  begin
    hit    = 1'b1;
    rd_val = '0;
    case (offset)
      rp_pkg::HK_ID:        rd_val = `RP_HK_ID;
      rp_pkg::HK_LOOP:      rd_val[0] = digital_loop_o;
      rp_pkg::HK_EXP_P_DIR: rd_val[`RP_EXP_W-1:0] = exp_p_dir_o;
      rp_pkg::HK_EXP_N_DIR: rd_val[`RP_EXP_W-1:0] = exp_n_dir_o;
      rp_pkg::HK_EXP_P_OUT: rd_val[`RP_EXP_W-1:0] = exp_p_dat_o;
      rp_pkg::HK_EXP_N_OUT: rd_val[`RP_EXP_W-1:0] = exp_n_dat_o;
      rp_pkg::HK_EXP_P_IN:  rd_val[`RP_EXP_W-1:0] = exp_p_dat_i;  // pin level
      rp_pkg::HK_EXP_N_IN:  rd_val[`RP_EXP_W-1:0] = exp_n_dat_i;
      rp_pkg::HK_LED:       rd_val[`RP_LED_W-1:0] = led_o;
      default:              hit = 1'b0;          // err, zero data
    endcase
  end

  ////////////////////////////////////////////////////
  // control registers and response
  ////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      led_o          <= '0;
      exp_p_dat_o    <= '0;
      exp_n_dat_o    <= '0;
      exp_p_dir_o    <= '0;                     // all pins input
      exp_n_dir_o    <= '0;
      digital_loop_o <= 1'b0;
      bus.ack        <= 1'b0;
      bus.err        <= 1'b0;
    end
    else
    begin
      bus.ack <= bus.wen | bus.ren;
      bus.err <= (bus.wen | bus.ren) & ~hit;
      if (bus.wen)
      begin
        case (offset)
          rp_pkg::HK_LOOP:      digital_loop_o <= bus.wdata[0];
          rp_pkg::HK_EXP_P_DIR: exp_p_dir_o <= bus.wdata[`RP_EXP_W-1:0];
          rp_pkg::HK_EXP_N_DIR: exp_n_dir_o <= bus.wdata[`RP_EXP_W-1:0];
          rp_pkg::HK_EXP_P_OUT: exp_p_dat_o <= bus.wdata[`RP_EXP_W-1:0];
          rp_pkg::HK_EXP_N_OUT: exp_n_dat_o <= bus.wdata[`RP_EXP_W-1:0];
          rp_pkg::HK_LED:       led_o <= bus.wdata[`RP_LED_W-1:0];
          default:              ;               // read only or unmapped
        endcase
      end
    end
  end

  // read data follows every strobe
  always_ff @(posedge adc_clk)
  begin
    if (bus.wen | bus.ren)
      bus.rdata <= rd_val;
  end

endmodule

//--- verilog/analog_regs.sv
/*
 * region 1: DAC level per channel, latest ADC sample per channel
 * samples read back sign-extended to 32 bits, DAC write takes wdata[13:0]
 * offset decode uses addr[7:0] only
 */
`include "rp_defines.svh"

module analog_regs (
  input  logic            adc_clk,
  input  logic            rst_i,
  sys_bus_if.slave        bus,
  input  rp_pkg::sample_t adc_a_i,
  input  rp_pkg::sample_t adc_b_i,
  output rp_pkg::sample_t dac_a_o,
  output rp_pkg::sample_t dac_b_o
);

  localparam int EXT_W = `RP_BUS_W - `RP_ADC_W;  // sign extension bits

  rp_pkg::analog_reg_e  offset;
  rp_pkg::sample_t      adc_a_q, adc_b_q;        // readback copies
  logic                 hit;
  logic [`RP_BUS_W-1:0] rd_val;

  assign offset = rp_pkg::analog_reg_e'(bus.addr[7:0]);

  // sample capture, every cycle
  always_ff @(posedge adc_clk)
  begin
    adc_a_q <= adc_a_i;
    adc_b_q <= adc_b_i;
  end

  always_comb
  begin
    hit    = 1'b1;
    rd_val = '0;
    case (offset)
      rp_pkg::AN_DAC_A: rd_val = {{EXT_W{dac_a_o[`RP_ADC_W-1]}}, dac_a_o};
      rp_pkg::AN_DAC_B: rd_val = {{EXT_W{dac_b_o[`RP_ADC_W-1]}}, dac_b_o};
      rp_pkg::AN_ADC_A: rd_val = {{EXT_W{adc_a_q[`RP_ADC_W-1]}}, adc_a_q};
      rp_pkg::AN_ADC_B: rd_val = {{EXT_W{adc_b_q[`RP_ADC_W-1]}}, adc_b_q};
      default:          hit = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////
  // DAC levels and response
  ////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      dac_a_o <= '0;                            // mid-scale on the pins
      dac_b_o <= '0;
      bus.ack <= 1'b0;
      bus.err <= 1'b0;
    end
    else
    begin
      bus.ack <= bus.wen | bus.ren;
      bus.err <= (bus.wen | bus.ren) & ~hit;
      if (bus.wen && offset == rp_pkg::AN_DAC_A)
        dac_a_o <= rp_pkg::sample_t'(bus.wdata[`RP_ADC_W-1:0]);
      if (bus.wen && offset == rp_pkg::AN_DAC_B)
        dac_b_o <= rp_pkg::sample_t'(bus.wdata[`RP_ADC_W-1:0]);
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (bus.wen | bus.ren)
      bus.rdata <= rd_val;
  end

endmodule

//--- verilog/analog_io.sv
/*
 * ADC and DAC pin side; pins use a negative-slope offset code
 * ADC pin bits 1:0 are dropped, DAC pins come out as two plain buses
 * loopback replaces the ADC samples with the DAC levels
 */
`include "rp_defines.svh"

module analog_io (
  input  logic                    adc_clk,
  input  logic                    rst_i,
  input  logic [`RP_ADC_PIN_W-1:0] adc_dat_a_i,
  input  logic [`RP_ADC_PIN_W-1:0] adc_dat_b_i,
  input  logic                    digital_loop_i,
  input  rp_pkg::sample_t         dac_a_i,
  input  rp_pkg::sample_t         dac_b_i,
  output rp_pkg::sample_t         adc_a_o,
  output rp_pkg::sample_t         adc_b_o,
  output logic [`RP_ADC_W-1:0]    dac_dat_a_o,
  output logic [`RP_ADC_W-1:0]    dac_dat_b_o
);

  logic [`RP_ADC_W-1:0] adc_a_q, adc_b_q;       // raw pin code

  // input registers, top 14 pin bits
  always_ff @(posedge adc_clk)
  begin
    adc_a_q <= adc_dat_a_i[`RP_ADC_PIN_W-1 -: `RP_ADC_W];
    adc_b_q <= adc_dat_b_i[`RP_ADC_PIN_W-1 -: `RP_ADC_W];
  end

  // neg-slope code to two's complement, keep msb, flip the rest
  assign adc_a_o = digital_loop_i ? dac_a_i :
                   rp_pkg::sample_t'({adc_a_q[`RP_ADC_W-1], ~adc_a_q[`RP_ADC_W-2:0]});
  assign adc_b_o = digital_loop_i ? dac_b_i :
                   rp_pkg::sample_t'({adc_b_q[`RP_ADC_W-1], ~adc_b_q[`RP_ADC_W-2:0]});

  // DAC output registers, same mapping back to pin code
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      dac_dat_a_o <= {1'b0, {(`RP_ADC_W-1){1'b1}}};  // level 0, mid-scale
      dac_dat_b_o <= {1'b0, {(`RP_ADC_W-1){1'b1}}};
    end
    else
    begin
      dac_dat_a_o <= {dac_a_i[`RP_ADC_W-1], ~dac_a_i[`RP_ADC_W-2:0]};
      dac_dat_b_o <= {dac_b_i[`RP_ADC_W-1], ~dac_b_i[`RP_ADC_W-2:0]};
    end
  end

endmodule

//--- verilog/rp_top.sv
/*
 * fast analog edge plus register bus, everything on adc_clk
 * expansion pins come as separate in, out and direction buses
 * bus host must follow the single-strobe, wait-for-ack rule
 */
`include "rp_defines.svh"

module rp_top (
  input  logic                    adc_clk,
  input  logic                    rst_i,
  // system bus
  input  logic [`RP_BUS_W-1:0]    sys_addr_i,
  input  logic [`RP_BUS_W-1:0]    sys_wdata_i,
  input  logic                    sys_wen_i,
  input  logic                    sys_ren_i,
  output logic [`RP_BUS_W-1:0]    sys_rdata_o,
  output logic                    sys_err_o,
  output logic                    sys_ack_o,
  // converters
  input  logic [`RP_ADC_PIN_W-1:0] adc_dat_a_i,
  input  logic [`RP_ADC_PIN_W-1:0] adc_dat_b_i,
  output logic [`RP_ADC_W-1:0]    dac_dat_a_o,
  output logic [`RP_ADC_W-1:0]    dac_dat_b_o,
  // expansion connector and LEDs
  input  logic [`RP_EXP_W-1:0]    exp_p_dat_i,
  input  logic [`RP_EXP_W-1:0]    exp_n_dat_i,
  output logic [`RP_EXP_W-1:0]    exp_p_dat_o,
  output logic [`RP_EXP_W-1:0]    exp_n_dat_o,
  output logic [`RP_EXP_W-1:0]    exp_p_dir_o,  // 1 = drive pin
  output logic [`RP_EXP_W-1:0]    exp_n_dir_o,
  output logic [`RP_LED_W-1:0]    led_o
);

  sys_bus_if hk_bus ();                         // region 0
  sys_bus_if analog_bus ();                     // region 1

  logic            digital_loop;
  rp_pkg::sample_t adc_a, adc_b;                // converted samples
  rp_pkg::sample_t dac_a, dac_b;                // DAC levels

  sys_bus_decoder sys_bus_decoder_inst (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_err_o   (sys_err_o),
    .sys_ack_o   (sys_ack_o),
    .hk_bus      (hk_bus.decoder),
    .analog_bus  (analog_bus.decoder)
  );

  housekeeping_regs housekeeping_regs_inst (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .bus            (hk_bus.slave),
    .exp_p_dat_i    (exp_p_dat_i),
    .exp_n_dat_i    (exp_n_dat_i),
    .led_o          (led_o),
    .exp_p_dat_o    (exp_p_dat_o),
    .exp_n_dat_o    (exp_n_dat_o),
    .exp_p_dir_o    (exp_p_dir_o),
    .exp_n_dir_o    (exp_n_dir_o),
    .digital_loop_o (digital_loop)
  );

  analog_regs analog_regs_inst (
    .adc_clk (adc_clk),
    .rst_i   (rst_i),
    .bus     (analog_bus.slave),
    .adc_a_i (adc_a),
    .adc_b_i (adc_b),
    .dac_a_o (dac_a),
    .dac_b_o (dac_b)
  );

  analog_io analog_io_inst (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .dac_a_i        (dac_a),
    .dac_b_i        (dac_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b),
    .dac_dat_a_o    (dac_dat_a_o),
    .dac_dat_b_o    (dac_dat_b_o)
  );

endmodule

//--- tb/rp_top_chk.sv
/*
 * concurrent checks on the rp_top ports, bound into every rp_top
 * assumes a host with one open strobe at a time
 * fail_count is read by the testbench at the end of the run
 */
`include "rp_defines.svh"

module rp_top_chk (
  input logic                                adc_clk,
  input logic                                rst_i,
  input logic [`RP_BUS_W-1:0]                addr_i,
  input logic                                wen_i,
  input logic                                ren_i,
  input logic                                ack_i,
  input logic                                err_i,
  input logic [`RP_LED_W+4*`RP_EXP_W-1:0]    ctrl_i   // leds, exp dir and out
);

  int unsigned fail_count = 0;
  logic        strobe;
  logic        slave_hit;                       // region 0 or 1

  assign strobe    = wen_i | ren_i;
  assign slave_hit = addr_i[`RP_REGION_LSB +: 3] <= 3'(rp_pkg::REGION_ANALOG);

  //////////////////////////////////////////////////
  // reset state
  //////////////////////////////////////////////////

  reset_clear: assert property (@(posedge adc_clk)
    rst_i |=> (ctrl_i == '0 && !ack_i && !err_i))
  else
  begin
    fail_count++;
    $error("control outputs not cleared by reset");
  end

  //////////////////////////////////////////////////
  // bus response
  //////////////////////////////////////////////////

  err_with_ack: assert property (@(posedge adc_clk) disable iff (rst_i)
    err_i |-> ack_i)
  else
  begin
    fail_count++;
    $error("sys_err_o high without sys_ack_o");
  end

  ack_single: assert property (@(posedge adc_clk) disable iff (rst_i)
    ack_i |=> !ack_i)
  else
  begin
    fail_count++;
    $error("sys_ack_o high for two cycles");
  end

  // empty regions answer one cycle after the strobe
  unused_ack: assert property (@(posedge adc_clk) disable iff (rst_i)
    strobe && !slave_hit |=> ack_i)
  else
  begin
    fail_count++;
    $error("unused region not acked one cycle after the strobe");
  end

  // register blocks, one more cycle through the decoder
  slave_ack: assert property (@(posedge adc_clk) disable iff (rst_i)
    strobe && slave_hit |=> !ack_i ##1 ack_i)
  else
  begin
    fail_count++;
    $error("register block not acked two cycles after the strobe");
  end

  ack_source: assert property (@(posedge adc_clk) disable iff (rst_i)
    ack_i |-> $past(strobe) || $past(strobe, 2))
  else
  begin
    fail_count++;
    $error("sys_ack_o without a strobe 1 or 2 cycles before");
  end

endmodule

bind rp_top rp_top_chk rp_top_chk_inst (
  .adc_clk (adc_clk),
  .rst_i   (rst_i),
  .addr_i  (sys_addr_i),
  .wen_i   (sys_wen_i),
  .ren_i   (sys_ren_i),
  .ack_i   (sys_ack_o),
  .err_i   (sys_err_o),
  .ctrl_i  ({led_o, exp_p_dir_o, exp_n_dir_o, exp_p_dat_o, exp_n_dat_o})
);

//--- tb/rp_top_tb.sv
/*
 * testbench for rp_top in a single adc_clk domain
 * host keeps one strobe open and waits for ack
 * outputs sampled at negedge
 * rp_top_chk comes in through bind
 */
`include "rp_defines.svh"

module rp_top_tb;

  localparam int ACK_TIMEOUT = 16;              // cycles per access

  logic                     adc_clk;
  logic                     rst_i;
  logic [`RP_BUS_W-1:0]     sys_addr_i;
  logic [`RP_BUS_W-1:0]     sys_wdata_i;
  logic                     sys_wen_i;
  logic                     sys_ren_i;
  logic [`RP_BUS_W-1:0]     sys_rdata_o;
  logic                     sys_err_o;
  logic                     sys_ack_o;
  logic [`RP_ADC_PIN_W-1:0] adc_dat_a_i;
  logic [`RP_ADC_PIN_W-1:0] adc_dat_b_i;
  logic [`RP_ADC_W-1:0]     dac_dat_a_o;
  logic [`RP_ADC_W-1:0]     dac_dat_b_o;
  logic [`RP_EXP_W-1:0]     exp_p_dat_i;
  logic [`RP_EXP_W-1:0]     exp_n_dat_i;
  logic [`RP_EXP_W-1:0]     exp_p_dat_o;
  logic [`RP_EXP_W-1:0]     exp_n_dat_o;
  logic [`RP_EXP_W-1:0]     exp_p_dir_o;
  logic [`RP_EXP_W-1:0]     exp_n_dir_o;
  logic [`RP_LED_W-1:0]     led_o;

  int     errors = 0;
  int     checks = 0;
  integer seed;                                 // $random state

  rp_top rp_top_inst (.*);

  initial
  begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;             // period 20
  end

  //////////////////////////////////////////////////
  // expected values
  //////////////////////////////////////////////////

  function automatic logic [31:0] region_addr(input int region, input logic [7:0] offset);
    region_addr = (32'(region) << `RP_REGION_LSB) | 32'(offset);
  endfunction

  // sign extend a 14-bit sample to the bus
  function automatic logic [31:0] widen(input logic [13:0] v);
    widen = 32'($signed(v));
  endfunction

  // pin bits 15:2 with msb kept and lower 13 flipped
  function automatic logic [31:0] adc_expect(input logic [15:0] pins);
    adc_expect = widen(pins[15:2] ^ 14'h1FFF);
  endfunction

  //////////////////////////////////////////////////
  // bus access
  //////////////////////////////////////////////////

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic run_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rd, output logic err, output int lat);
    int cnt;
    cnt = 0;
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= wdata;
    sys_wen_i   <= wr;
    sys_ren_i   <= ~wr;
    @(posedge adc_clk);                         // strobe taken here
    sys_wen_i <= 1'b0;
    sys_ren_i <= 1'b0;
    do
    begin
      @(negedge adc_clk);
      cnt++;
    end while (!sys_ack_o && cnt < ACK_TIMEOUT);
    if (!sys_ack_o)
    begin
      $display("timeout: no sys_ack_o for address %h", addr);
      $display("** FAIL **");
      $finish;
    end
    else
    begin
      rd  = sys_rdata_o;
      err = sys_err_o;
      lat = cnt;                                // cycles after the strobe
    end
  endtask

  task automatic write_reg(input string name, input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    int          lat;
    run_access(1'b1, addr, data, rd, err, lat);
    expect_eq({name, " err"}, 0, 32'(err));
  endtask

  task automatic read_reg(input logic [31:0] addr, output logic [31:0] rd,
                          output logic err, output int lat);
    run_access(1'b0, addr, '0, rd, err, lat);
  endtask

  task automatic expect_read(input string name, input logic [31:0] addr,
                             input logic [31:0] exp, input int exp_lat);
    logic [31:0] rd;
    logic        err;
    int          lat;
    read_reg(addr, rd, err, lat);
    expect_eq({name, " data"}, exp, rd);
    expect_eq({name, " err"}, 0, 32'(err));
    expect_eq({name, " latency"}, 32'(exp_lat), 32'(lat));
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial
  begin
    logic [31:0] rd;
    logic        err;
    int          lat;
    logic [15:0] pins_a, pins_b;
    logic [13:0] lvl_a, lvl_b;
    logic [7:0]  hk_off [5];
    logic [31:0] hk_val [5];
    int          asrt_fails;

    seed        = 32'h369e;
    rst_i       <= 1'b1;
    sys_addr_i  <= '0;
    sys_wdata_i <= '0;
    sys_wen_i   <= 1'b0;
    sys_ren_i   <= 1'b0;
    adc_dat_a_i <= '0;
    adc_dat_b_i <= '0;
    exp_p_dat_i <= '0;
    exp_n_dat_i <= '0;
    repeat (10) @(posedge adc_clk);
    rst_i <= 1'b0;
    @(negedge adc_clk);

    // reset state with DAC pins at mid-scale
    expect_eq("reset led", 0, 32'(led_o));
    expect_eq("reset exp dir", 0, 32'({exp_p_dir_o, exp_n_dir_o}));
    expect_eq("reset exp out", 0, 32'({exp_p_dat_o, exp_n_dat_o}));
    expect_eq("reset ack err", 0, 32'({sys_ack_o, sys_err_o}));
    expect_eq("reset dac a", 32'h1FFF, 32'(dac_dat_a_o));
    expect_eq("reset dac b", 32'h1FFF, 32'(dac_dat_b_o));
    expect_read("reset loop", region_addr(0, rp_pkg::HK_LOOP), 0, 2);

    // empty regions give zero data in one cycle and drop writes
    for (int r = 2; r < `RP_REGIONS; r++)
      expect_read("unused read", region_addr(r, 8'(4 * r)), 0, 1);
    write_reg("unused write led", region_addr(5, rp_pkg::HK_LED), 32'hFF);
    write_reg("unused write dac", region_addr(3, rp_pkg::AN_DAC_A), 32'h1234);
    expect_eq("unused write led", 0, 32'(led_o));
    expect_eq("unused write dac", 32'h1FFF, 32'(dac_dat_a_o));

    // housekeeping control registers
    hk_off = '{rp_pkg::HK_LED, rp_pkg::HK_EXP_P_DIR, rp_pkg::HK_EXP_N_DIR,
               rp_pkg::HK_EXP_P_OUT, rp_pkg::HK_EXP_N_OUT};
    for (int i = 0; i < 5; i++)
    begin
      hk_val[i] = 32'($random(seed)) & 32'hFF;
      write_reg("hk write", region_addr(0, hk_off[i]), hk_val[i]);
    end
    expect_eq("hk led_o", hk_val[0], 32'(led_o));
    expect_eq("hk exp_p_dir_o", hk_val[1], 32'(exp_p_dir_o));
    expect_eq("hk exp_n_dir_o", hk_val[2], 32'(exp_n_dir_o));
    expect_eq("hk exp_p_dat_o", hk_val[3], 32'(exp_p_dat_o));
    expect_eq("hk exp_n_dat_o", hk_val[4], 32'(exp_n_dat_o));
    for (int i = 0; i < 5; i++)
      expect_read("hk readback", region_addr(0, hk_off[i]), hk_val[i], 2);
    expect_read("hk id", region_addr(0, rp_pkg::HK_ID), `RP_HK_ID, 2);
    @(posedge adc_clk);
    exp_p_dat_i <= 8'($random(seed));
    exp_n_dat_i <= 8'($random(seed));
    @(negedge adc_clk);
    expect_read("hk exp p in", region_addr(0, rp_pkg::HK_EXP_P_IN), 32'(exp_p_dat_i), 2);
    expect_read("hk exp n in", region_addr(0, rp_pkg::HK_EXP_N_IN), 32'(exp_n_dat_i), 2);
    read_reg(region_addr(0, 8'h08), rd, err, lat);   // hole in the map
    expect_eq("hk unmapped data", 0, rd);
    expect_eq("hk unmapped err", 1, 32'(err));

    // DAC levels to pin code
    lvl_a = 14'($random(seed));
    lvl_b = 14'($random(seed));
    write_reg("dac a", region_addr(1, rp_pkg::AN_DAC_A), widen(lvl_a));
    expect_eq("dac a pins", 32'(lvl_a ^ 14'h1FFF), 32'(dac_dat_a_o));
    write_reg("dac b", region_addr(1, rp_pkg::AN_DAC_B), widen(lvl_b));
    expect_eq("dac b pins", 32'(lvl_b ^ 14'h1FFF), 32'(dac_dat_b_o));

    // ADC readback with random pins
    for (int n = 0; n < 4; n++)
    begin
      pins_a = 16'($random(seed));
      pins_b = 16'($random(seed));
      @(posedge adc_clk);
      adc_dat_a_i <= pins_a;
      adc_dat_b_i <= pins_b;
      repeat (3) @(posedge adc_clk);            // pin reg plus readback reg
      expect_read("adc a", region_addr(1, rp_pkg::AN_ADC_A), adc_expect(pins_a), 2);
      expect_read("adc b", region_addr(1, rp_pkg::AN_ADC_B), adc_expect(pins_b), 2);
    end

    // loopback ignores the pins
    write_reg("loop on", region_addr(0, rp_pkg::HK_LOOP), 1);
    pins_a = 16'($random(seed));
    pins_b = 16'($random(seed));
    @(posedge adc_clk);
    adc_dat_a_i <= pins_a;
    adc_dat_b_i <= pins_b;
    repeat (3) @(posedge adc_clk);
    expect_read("loop adc a", region_addr(1, rp_pkg::AN_ADC_A), widen(lvl_a), 2);
    expect_read("loop adc b", region_addr(1, rp_pkg::AN_ADC_B), widen(lvl_b), 2);
    write_reg("loop off", region_addr(0, rp_pkg::HK_LOOP), 0);
    expect_read("unloop adc a", region_addr(1, rp_pkg::AN_ADC_A), adc_expect(pins_a), 2);
    expect_read("unloop adc b", region_addr(1, rp_pkg::AN_ADC_B), adc_expect(pins_b), 2);

    repeat (2) @(posedge adc_clk);              // last assertions settle
    asrt_fails = rp_top_inst.rp_top_chk_inst.fail_count;
    $display("checks %0d, compare errors %0d, assertion failures %0d",
             checks, errors, asrt_fails);
    if (errors == 0 && asrt_fails == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

//--- sources.f
+incdir+verilog
verilog/rp_pkg.sv
verilog/sys_bus_if.sv
verilog/sys_bus_decoder.sv
verilog/housekeeping_regs.sv
verilog/analog_regs.sv
verilog/analog_io.sv
verilog/rp_top.sv
tb/rp_top_chk.sv
tb/rp_top_tb.sv
